// ==== rtl/rename_params.svh ====
// Size constants for the two-wide rename stage, included by every RTL file that needs them
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Instructions renamed per cycle
`define RN_SLOTS 2
// RV32I integer register file
`define RN_ARCH_REGS 32
// Physical register file, twice the architectural count
`define RN_PHYS_REGS 64
`define RN_PREG_W 6
// Input queue depth in instruction pairs
`define RN_IQ_DEPTH 4
// Reorder-buffer tag width
`define RN_TAG_W 4

`endif

// ==== rtl/rename_pkg.sv ====
// Shared types of the rename stage: instruction word views, decoded slots and dispatch entries
package rename_pkg;

    `include "rename_params.svh"

    // Register index types
    typedef logic [$clog2(`RN_ARCH_REGS)-1:0] areg_t;
    typedef logic [`RN_PREG_W-1:0] preg_t;
    typedef logic [`RN_TAG_W-1:0] tag_t;
    // Free list occupancy, 0 up to the number of spare registers
    typedef logic [$clog2(`RN_PHYS_REGS - `RN_ARCH_REGS + 1)-1:0] fl_count_t;

    // R-type layout, rd sits in bits 11:7
    typedef struct packed {
        logic [6:0] funct7;
        areg_t      rs2;
        areg_t      rs1;
        logic [2:0] funct3;
        areg_t      rd;
        logic [6:0] opcode;
    } r_view_t;

    // S/B-type layout, the rd bits hold the low immediate
    typedef struct packed {
        logic [6:0] imm_hi;
        areg_t      rs2;
        areg_t      rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_view_t;

    // Same 32-bit word seen through either layout
    typedef union packed {
        r_view_t r_view;
        s_view_t s_view;
    } inst_word_u;

    // Slot after decode, only the fields renaming needs
    typedef struct packed {
        logic       slot_valid;
        inst_word_u word;
        areg_t      rs1;
        logic       uses_rs1;
        areg_t      rs2;
        logic       uses_rs2;
        areg_t      rd;
        // Already false for x0
        logic       has_rd;
    } decoded_slot_t;

    // Renamed slot as handed downstream
    typedef struct packed {
        logic       slot_valid;
        inst_word_u word;
        preg_t      rs1;
        logic       rs1_ready;
        preg_t      rs2;
        logic       rs2_ready;
        preg_t      rd;
        logic       has_rd;
        tag_t       tag;
    } dispatch_entry_t;

endpackage

// ==== rtl/rename_if.sv ====
// Lookup and allocate channel between the dispatcher and the rename map
`timescale 1ns/1ps
`include "rename_params.svh"

interface rename_if;
    import rename_pkg::*;

    // Requests from the dispatcher
    areg_t rs1_arch [`RN_SLOTS];
    areg_t rs2_arch [`RN_SLOTS];
    areg_t rd_arch [`RN_SLOTS];
    logic [`RN_SLOTS-1:0] alloc_en;
    logic [`RN_SLOTS-1:0] map_write;
    logic fire;

    // Answers from the map, all combinational
    preg_t rs1_preg [`RN_SLOTS];
    preg_t rs2_preg [`RN_SLOTS];
    logic [`RN_SLOTS-1:0] rs1_busy;
    logic [`RN_SLOTS-1:0] rs2_busy;
    preg_t alloc_preg [`RN_SLOTS];
    fl_count_t free_count;

    modport dispatcher (
        output rs1_arch, rs2_arch, rd_arch, alloc_en, map_write, fire,
        input  rs1_preg, rs2_preg, rs1_busy, rs2_busy, alloc_preg, free_count
    );

    modport map (
        input  rs1_arch, rs2_arch, rd_arch, alloc_en, map_write, fire,
        output rs1_preg, rs2_preg, rs1_busy, rs2_busy, alloc_preg, free_count
    );

endinterface

// ==== rtl/inst_queue.sv ====
// Input side of the rename stage, decodes incoming pairs and holds them in a small FIFO
`timescale 1ns/1ps
`include "rename_params.svh"

module inst_queue (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  rename_pkg::inst_word_u    in_word [`RN_SLOTS],
    output logic                      head_valid,
    output rename_pkg::decoded_slot_t head_slots [`RN_SLOTS],
    input  logic                      head_pop
);
    import rename_pkg::*;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef logic [$clog2(`RN_IQ_DEPTH)-1:0] iq_ptr_t;
    typedef logic [$clog2(`RN_IQ_DEPTH + 1)-1:0] iq_count_t;

    decoded_slot_t q_mem [`RN_IQ_DEPTH][`RN_SLOTS];
    iq_ptr_t wr_ptr;
    iq_ptr_t rd_ptr;
    iq_count_t count;
    logic push;

    // Pull out source and destination use from the opcode
    function automatic decoded_slot_t decode_slot(inst_word_u w);
        decoded_slot_t d;
        d = '0;
        d.slot_valid = (w != '0);
        d.word = w;
        case (w.r_view.opcode)
            OPC_OP: begin
                d.uses_rs1 = 1'b1;
                d.uses_rs2 = 1'b1;
                d.rs2 = w.r_view.rs2;
                d.has_rd = 1'b1;
            end
            // No rd here, bits 11:7 are immediate
            OPC_STORE, OPC_BRANCH: begin
                d.uses_rs1 = 1'b1;
                d.uses_rs2 = 1'b1;
                d.rs2 = w.s_view.rs2;
            end
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
                d.uses_rs1 = 1'b1;
                d.has_rd = 1'b1;
            end
            OPC_LUI, OPC_AUIPC, OPC_JAL: d.has_rd = 1'b1;
            default: d.has_rd = 1'b0;
        endcase
        // Unused sources read x0 so their lookup is harmless
        d.rs1 = d.uses_rs1 ? w.r_view.rs1 : '0;
        d.rd = w.r_view.rd;
        // x0 is never renamed
        d.has_rd = d.has_rd && (w.r_view.rd != '0);
        return d;
    endfunction

    assign in_ready = (count != iq_count_t'(`RN_IQ_DEPTH));
    assign push = in_valid && in_ready;
    assign head_valid = (count != '0);
    assign head_slots = q_mem[rd_ptr];

    // Pair storage, payload only
    always_ff @(posedge clk) begin
        if (push) begin
            for (int s = 0; s < `RN_SLOTS; s++) begin
                q_mem[wr_ptr][s] <= decode_slot(in_word[s]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (head_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + iq_count_t'(push) - iq_count_t'(head_pop);
        end
    end

    // The dispatcher may only fire on a pair that is really there
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) head_pop |-> head_valid);

endmodule

// ==== rtl/rename_map.sv ====
// Register alias table, free list and busy bits, looked up and updated by the dispatcher
`timescale 1ns/1ps
`include "rename_params.svh"

module rename_map (
    input  logic              clk,
    input  logic              rst,
    rename_if.map             map,
    input  logic              wb_valid,
    input  rename_pkg::preg_t wb_preg,
    input  logic              rel_valid,
    input  rename_pkg::preg_t rel_preg
);
    import rename_pkg::*;

    // Spare registers beyond the architectural set
    localparam int FL_DEPTH = `RN_PHYS_REGS - `RN_ARCH_REGS;
    typedef logic [$clog2(FL_DEPTH)-1:0] fl_ptr_t;

    preg_t rat [`RN_ARCH_REGS];
    preg_t fl_mem [FL_DEPTH];
    fl_ptr_t fl_head;
    fl_ptr_t fl_tail;
    fl_count_t fl_count;
    logic [`RN_PHYS_REGS-1:0] busy_q;

    // Head after this cycle's pops and number of registers requested
    fl_ptr_t alloc_ptr;
    fl_count_t n_pop;

    // Source lookup, no bypass of this cycle's updates
    always_comb begin
        for (int s = 0; s < `RN_SLOTS; s++) begin
            map.rs1_preg[s] = rat[map.rs1_arch[s]];
            map.rs2_preg[s] = rat[map.rs2_arch[s]];
            map.rs1_busy[s] = busy_q[rat[map.rs1_arch[s]]];
            map.rs2_busy[s] = busy_q[rat[map.rs2_arch[s]]];
        end
    end

    // Slots with a destination take consecutive entries from the head
    always_comb begin
        alloc_ptr = fl_head;
        n_pop = '0;
        for (int s = 0; s < `RN_SLOTS; s++) begin
            map.alloc_preg[s] = fl_mem[alloc_ptr];
            if (map.alloc_en[s]) begin
                alloc_ptr = alloc_ptr + 1'b1;
                n_pop = n_pop + 1'b1;
            end
        end
    end

    assign map.free_count = fl_count;

    // Alias table starts as identity, x0 stays on register 0
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < `RN_ARCH_REGS; a++) begin
                rat[a] <= preg_t'(a);
            end
        end else if (map.fire) begin
            for (int s = 0; s < `RN_SLOTS; s++) begin
                if (map.map_write[s] && (map.rd_arch[s] != '0)) begin
                    rat[map.rd_arch[s]] <= map.alloc_preg[s];
                end
            end
        end
    end

    // Free list holds 32 to 63 in order after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= preg_t'(`RN_ARCH_REGS + i);
            end
            fl_head <= '0;
            fl_tail <= '0;
            fl_count <= fl_count_t'(FL_DEPTH);
        end else begin
            if (rel_valid) begin
                fl_mem[fl_tail] <= rel_preg;
                fl_tail <= fl_tail + 1'b1;
            end
            if (map.fire) begin
                fl_head <= alloc_ptr;
            end
            fl_count <= fl_count + fl_count_t'(rel_valid) - (map.fire ? n_pop : '0);
        end
    end

    // Writeback clears, a new allocation sets
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= '0;
        end else begin
            if (wb_valid) begin
                busy_q[wb_preg] <= 1'b0;
            end
            if (map.fire) begin
                for (int s = 0; s < `RN_SLOTS; s++) begin
                    if (map.alloc_en[s]) begin
                        busy_q[map.alloc_preg[s]] <= 1'b1;
                    end
                end
            end
        end
    end

    // Dispatcher gating must keep allocation within the list
    a_no_short_alloc: assert property (@(posedge clk) disable iff (rst)
        map.fire |-> n_pop <= fl_count);

    // Releases never overflow the spare set
    a_no_over_release: assert property (@(posedge clk) disable iff (rst)
        rel_valid |-> (int'(fl_count) - int'(map.fire ? n_pop : '0)) < FL_DEPTH);

    // Register 0 backs x0 and is never produced
    a_preg0_idle: assert property (@(posedge clk) disable iff (rst) !busy_q[0]);

endmodule

// ==== rtl/dispatcher.sv ====
// Forms renamed entries from the queue head, resolves in-pair dependences and assigns tags
`timescale 1ns/1ps
`include "rename_params.svh"

module dispatcher (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        head_valid,
    input  rename_pkg::decoded_slot_t   head_slots [`RN_SLOTS],
    output logic                        head_pop,
    rename_if.dispatcher                map,
    output logic                        disp_valid,
    input  logic                        disp_ready,
    output rename_pkg::dispatch_entry_t disp_entry [`RN_SLOTS]
);
    import rename_pkg::*;

    tag_t tag_q;
    tag_t next_tag;
    fl_count_t need;
    logic fire;

    // Fire only when every destination in the pair can get a register
    always_comb begin
        need = '0;
        for (int s = 0; s < `RN_SLOTS; s++) begin
            need = need + fl_count_t'(head_slots[s].has_rd);
        end
    end

    assign fire = head_valid && disp_ready && (map.free_count >= need);
    assign head_pop = fire;
    assign disp_valid = fire;
    assign map.fire = fire;

    // Map requests
    always_comb begin
        for (int s = 0; s < `RN_SLOTS; s++) begin
            map.rs1_arch[s] = head_slots[s].rs1;
            map.rs2_arch[s] = head_slots[s].rs2;
            map.rd_arch[s] = head_slots[s].rd;
            map.alloc_en[s] = head_slots[s].has_rd;
            map.map_write[s] = head_slots[s].has_rd;
            // A younger slot writing the same rd owns the table entry
            for (int t = s + 1; t < `RN_SLOTS; t++) begin
                if (head_slots[t].has_rd && (head_slots[t].rd == head_slots[s].rd)) begin
                    map.map_write[s] = 1'b0;
                end
            end
        end
    end

    // Renamed entries, tags in slot order over valid slots
    always_comb begin
        next_tag = tag_q;
        for (int s = 0; s < `RN_SLOTS; s++) begin
            disp_entry[s].slot_valid = head_slots[s].slot_valid;
            disp_entry[s].word = head_slots[s].word;
            disp_entry[s].rs1 = map.rs1_preg[s];
            disp_entry[s].rs1_ready = !head_slots[s].uses_rs1 || !map.rs1_busy[s];
            disp_entry[s].rs2 = map.rs2_preg[s];
            disp_entry[s].rs2_ready = !head_slots[s].uses_rs2 || !map.rs2_busy[s];
            // Sources produced earlier in the pair take that new register
            // The latest older producer wins
            for (int t = 0; t < s; t++) begin
                if (head_slots[s].uses_rs1 && head_slots[t].has_rd &&
                    (head_slots[t].rd == head_slots[s].rs1)) begin
                    disp_entry[s].rs1 = map.alloc_preg[t];
                    disp_entry[s].rs1_ready = 1'b0;
                end
                if (head_slots[s].uses_rs2 && head_slots[t].has_rd &&
                    (head_slots[t].rd == head_slots[s].rs2)) begin
                    disp_entry[s].rs2 = map.alloc_preg[t];
                    disp_entry[s].rs2_ready = 1'b0;
                end
            end
            disp_entry[s].has_rd = head_slots[s].has_rd;
            disp_entry[s].rd = head_slots[s].has_rd ? map.alloc_preg[s] : '0;
            disp_entry[s].tag = next_tag;
            if (head_slots[s].slot_valid) begin
                next_tag = next_tag + 1'b1;
            end
        end
    end

    // Running reorder-buffer tag
    always_ff @(posedge clk) begin
        if (rst) begin
            tag_q <= '0;
        end else if (fire) begin
            tag_q <= next_tag;
        end
    end

endmodule

// ==== rtl/dispatch_buffer.sv ====
// Output register of the rename stage, holds one renamed pair for the downstream handshake
`timescale 1ns/1ps
`include "rename_params.svh"

module dispatch_buffer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        disp_valid,
    output logic                        disp_ready,
    input  rename_pkg::dispatch_entry_t disp_entry [`RN_SLOTS],
    output logic                        out_valid,
    input  logic                        out_ready,
    output rename_pkg::dispatch_entry_t out_entry [`RN_SLOTS]
);
    import rename_pkg::*;

    logic valid_q;
    dispatch_entry_t entry_q [`RN_SLOTS];

    // Refill in the same cycle the old pair leaves
    assign disp_ready = !valid_q || out_ready;
    assign out_valid = valid_q;
    assign out_entry = entry_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (disp_valid && disp_ready) begin
            valid_q <= 1'b1;
        end else if (out_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid && disp_ready) begin
            entry_q <= disp_entry;
        end
    end

    // A stalled pair must not change under the consumer
    for (genvar s = 0; s < `RN_SLOTS; s++) begin : g_hold
        a_hold: assert property (@(posedge clk) disable iff (rst)
            out_valid && !out_ready |=> out_valid && $stable(out_entry[s]));
    end

endmodule

// ==== rtl/rename_top.sv ====
// Top of the two-wide rename and dispatch stage, plain handshake ports on both sides
`timescale 1ns/1ps
`include "rename_params.svh"

module rename_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  rename_pkg::inst_word_u      in_word [`RN_SLOTS],
    output logic                        out_valid,
    input  logic                        out_ready,
    output rename_pkg::dispatch_entry_t out_entry [`RN_SLOTS],
    input  logic                        wb_valid,
    input  rename_pkg::preg_t           wb_preg,
    input  logic                        rel_valid,
    input  rename_pkg::preg_t           rel_preg
);
    import rename_pkg::*;

    // Queue head toward the dispatcher
    logic head_valid;
    logic head_pop;
    decoded_slot_t head_slots [`RN_SLOTS];
    // Renamed pair toward the output register
    logic disp_valid;
    logic disp_ready;
    dispatch_entry_t disp_entry [`RN_SLOTS];

    rename_if rif ();

    inst_queue u_inst_queue (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_word    (in_word),
        .head_valid (head_valid),
        .head_slots (head_slots),
        .head_pop   (head_pop)
    );

    dispatcher u_dispatcher (
        .clk        (clk),
        .rst        (rst),
        .head_valid (head_valid),
        .head_slots (head_slots),
        .head_pop   (head_pop),
        .map        (rif.dispatcher),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready),
        .disp_entry (disp_entry)
    );

    rename_map u_rename_map (
        .clk       (clk),
        .rst       (rst),
        .map       (rif.map),
        .wb_valid  (wb_valid),
        .wb_preg   (wb_preg),
        .rel_valid (rel_valid),
        .rel_preg  (rel_preg)
    );

    dispatch_buffer u_dispatch_buffer (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready),
        .disp_entry (disp_entry),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_entry  (out_entry)
    );

endmodule

// ==== verification/rename_tb.sv ====
// Table-driven testbench for rename_top that the run script in the project root builds from list.f
`timescale 1ns/1ps
`include "rename_params.svh"

module rename_tb;
    import rename_pkg::*;

    // Row kinds of the stimulus table
    localparam logic [1:0] K_PAIR = 2'd0;
    localparam logic [1:0] K_WB = 2'd1;
    localparam logic [1:0] K_REL = 2'd2;

    // One table row holding a pair with its expected entries or a side-band event
    typedef struct packed {
        logic [1:0]      kind;
        logic            starve;
        logic [7:0]      stall;
        preg_t           preg;
        inst_word_u      w0;
        inst_word_u      w1;
        dispatch_entry_t e0;
        dispatch_entry_t e1;
    } row_t;

    logic clk;
    logic rst;
    logic in_valid;
    logic in_ready;
    inst_word_u in_word [`RN_SLOTS];
    logic out_valid;
    logic out_ready;
    dispatch_entry_t out_entry [`RN_SLOTS];
    logic wb_valid;
    preg_t wb_preg;
    logic rel_valid;
    preg_t rel_preg;

    row_t stim_q [$];
    int sent;
    int got;
    int cycles;
    int cycle_limit;
    logic saw_full;
    logic [31:0] lfsr_state;

    rename_top UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_word   (in_word),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_entry (out_entry),
        .wb_valid  (wb_valid),
        .wb_preg   (wb_preg),
        .rel_valid (rel_valid),
        .rel_preg  (rel_preg)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Hang guard scaled by table length
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            fail_run($sformatf("Timeout after %0d cycles with %0d of %0d pairs out",
                cycles, got, sent));
        end
    end

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_bit(string name, logic act, logic exp);
        if (act !== exp) begin
            fail_run($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, act, exp));
        end
    endtask

    task automatic check_preg(string name, preg_t act, preg_t exp);
        if (act !== exp) begin
            fail_run($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, act, exp));
        end
    endtask

    task automatic check_entry(string name, dispatch_entry_t act, dispatch_entry_t exp);
        if (act !== exp) begin
            fail_run($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, act, exp));
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Extra out_ready low cycles from 0 to 3
    function automatic int gap_cycles();
        int g;
        g = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            g = g * 2 + int'(lfsr_state[0]);
        end
        return g;
    endfunction

    // RV32I encoders for the few instructions used
    function automatic inst_word_u rtype_add(int rd, int rs1, int rs2);
        return {7'b0, areg_t'(rs2), areg_t'(rs1), 3'b000, areg_t'(rd), 7'b0110011};
    endfunction

    function automatic inst_word_u itype_addi(int rd, int rs1, int imm);
        return {12'(imm), areg_t'(rs1), 3'b000, areg_t'(rd), 7'b0010011};
    endfunction

    function automatic inst_word_u utype_lui(int rd, int imm);
        return {20'(imm), areg_t'(rd), 7'b0110111};
    endfunction

    // Store word built through the S view so imm_lo lands where rd would be
    function automatic inst_word_u stype_sw(int base, int src, int imm);
        inst_word_u w;
        logic [11:0] imm12;
        imm12 = 12'(imm);
        w.s_view.imm_hi = imm12[11:5];
        w.s_view.rs2 = areg_t'(src);
        w.s_view.rs1 = areg_t'(base);
        w.s_view.funct3 = 3'b010;
        w.s_view.imm_lo = imm12[4:0];
        w.s_view.opcode = 7'b0100011;
        return w;
    endfunction

    // Expected renamed fields only
    // Word and slot_valid come from the row itself
    function automatic dispatch_entry_t make_entry(int rs1, int r1, int rs2, int r2,
                                                   int rd, int hr, int tag);
        dispatch_entry_t e;
        e = '0;
        e.rs1 = preg_t'(rs1);
        e.rs1_ready = (r1 != 0);
        e.rs2 = preg_t'(rs2);
        e.rs2_ready = (r2 != 0);
        e.rd = preg_t'(rd);
        e.has_rd = (hr != 0);
        e.tag = tag_t'(tag);
        return e;
    endfunction

    task automatic pair_row(inst_word_u w0, inst_word_u w1, int stall, logic starve,
                            dispatch_entry_t e0, dispatch_entry_t e1);
        row_t r;
        r = '0;
        r.kind = K_PAIR;
        r.starve = starve;
        r.stall = 8'(stall);
        r.w0 = w0;
        r.w1 = w1;
        r.e0 = e0;
        r.e0.word = w0;
        r.e0.slot_valid = (w0 != '0);
        r.e1 = e1;
        r.e1.word = w1;
        r.e1.slot_valid = (w1 != '0);
        stim_q.push_back(r);
    endtask

    task automatic side_row(logic [1:0] kind, int preg);
        row_t r;
        r = '0;
        r.kind = kind;
        r.preg = preg_t'(preg);
        stim_q.push_back(r);
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    // Let every pair already sent leave the stage
    task automatic wait_drain();
        while (got != sent) begin
            step_cycle();
        end
    endtask

    task automatic drive_rows();
        row_t r;
        for (int i = 0; i < stim_q.size(); i++) begin
            r = stim_q[i];
            if (r.kind == K_PAIR) begin
                if (r.starve) begin
                    wait_drain();
                end
                in_word[0] = r.w0;
                in_word[1] = r.w1;
                in_valid = 1'b1;
                while (!in_ready) begin
                    saw_full = 1'b1;
                    step_cycle();
                end
                step_cycle();
                in_valid = 1'b0;
                sent++;
                // Free list is empty so nothing may come out
                if (r.starve) begin
                    repeat (20) begin
                        step_cycle();
                        check_bit("out_valid", out_valid, 1'b0);
                    end
                end
            end else begin
                if (r.kind == K_WB) begin
                    wait_drain();
                    wb_valid = 1'b1;
                    wb_preg = r.preg;
                end else begin
                    rel_valid = 1'b1;
                    rel_preg = r.preg;
                end
                step_cycle();
                wb_valid = 1'b0;
                rel_valid = 1'b0;
            end
        end
    endtask

    task automatic collect_rows();
        row_t r;
        int hold;
        dispatch_entry_t held [`RN_SLOTS];
        dispatch_entry_t exp_e [`RN_SLOTS];
        for (int i = 0; i < stim_q.size(); i++) begin
            r = stim_q[i];
            if (r.kind == K_PAIR) begin
                hold = int'(r.stall) + gap_cycles();
                while (!out_valid) begin
                    step_cycle();
                end
                // Stalled pair must sit still
                held = out_entry;
                repeat (hold) begin
                    step_cycle();
                    check_bit("out_valid", out_valid, 1'b1);
                    for (int s = 0; s < `RN_SLOTS; s++) begin
                        check_entry($sformatf("held out_entry[%0d]", s), out_entry[s], held[s]);
                    end
                end
                exp_e[0] = r.e0;
                exp_e[1] = r.e1;
                for (int s = 0; s < `RN_SLOTS; s++) begin
                    check_preg($sformatf("out_entry[%0d].rd", s), out_entry[s].rd, exp_e[s].rd);
                    check_entry($sformatf("out_entry[%0d]", s), out_entry[s], exp_e[s]);
                end
                out_ready = 1'b1;
                step_cycle();
                out_ready = 0;
                got++;
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        in_word[0] = '0;
        in_word[1] = '0;
        out_ready = 1'b0;
        wb_valid = 1'b0;
        wb_preg = '0;
        rel_valid = 1'b0;
        rel_preg = '0;
        sent = 0;
        got = 0;
        cycles = 0;
        saw_full = 1'b0;
        lfsr_state = 32'h95928e79;

        // First pair from reset state where slot 1 reads slot 0's rd
        pair_row(rtype_add(1, 2, 3), rtype_add(4, 1, 5), 0, 1'b0,
            make_entry(2, 1, 3, 1, 32, 1, 0), make_entry(32, 0, 5, 1, 33, 1, 1));
        // Both slots write x6 and only slot 1 lands in the table
        pair_row(itype_addi(6, 0, 1), itype_addi(6, 0, 2), 0, 1'b0,
            make_entry(0, 1, 0, 1, 34, 1, 2), make_entry(0, 1, 0, 1, 35, 1, 3));
        side_row(K_WB, 32);
        // Busy x6 and written-back x1 beside a store with rs2 from the S view
        pair_row(rtype_add(7, 6, 1), stype_sw(5, 4, 8), 0, 1'b0,
            make_entry(35, 0, 32, 1, 36, 1, 4), make_entry(5, 1, 33, 0, 0, 0, 5));
        // LUI without sources beside an rd of x0 that allocates nothing
        pair_row(utype_lui(9, 'h12345), itype_addi(0, 1, 5), 0, 1'b0,
            make_entry(0, 1, 0, 1, 37, 1, 6), make_entry(32, 1, 0, 1, 0, 0, 7));
        side_row(K_WB, 35);
        pair_row(rtype_add(10, 6, 7), itype_addi(11, 10, 1), 0, 1'b0,
            make_entry(35, 1, 36, 0, 38, 1, 8), make_entry(38, 0, 0, 1, 39, 1, 9));
        // Use up the rest of the free list
        for (int i = 1; i <= 12; i++) begin
            pair_row(itype_addi(12, 0, i), itype_addi(13, 0, i), 0, 1'b0,
                make_entry(0, 1, 0, 1, 38 + 2 * i, 1, 8 + 2 * i),
                make_entry(0, 1, 0, 1, 39 + 2 * i, 1, 9 + 2 * i));
        end
        // Starves until register 1 comes back
        pair_row(rtype_add(14, 10, 11), itype_addi(0, 0, 0), 0, 1'b1,
            make_entry(38, 0, 39, 0, 1, 1, 2), make_entry(0, 1, 0, 1, 0, 0, 3));
        side_row(K_REL, 1);
        // Store pairs behind a long output stall
        for (int j = 0; j < 8; j++) begin
            pair_row(stype_sw(3, 2, j), stype_sw(2, 5, j + 16), (j == 0) ? 12 : 0, 1'b0,
                make_entry(3, 1, 2, 1, 0, 0, 4 + 2 * j),
                make_entry(2, 1, 5, 1, 0, 0, 5 + 2 * j));
        end
        cycle_limit = stim_q.size() * 20;

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("in_ready", in_ready, 1'b1);

        fork
            drive_rows();
            collect_rows();
        join

        // Nothing duplicated after the last pair
        out_ready = 1'b1;
        repeat (10) begin
            step_cycle();
            check_bit("out_valid", out_valid, 1'b0);
        end
        if (!saw_full) begin
            fail_run("in_ready never dropped while out_ready was held low");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/rename_pkg.sv
rtl/rename_if.sv
rtl/inst_queue.sv
rtl/rename_map.sv
rtl/dispatcher.sv
rtl/dispatch_buffer.sv
rtl/rename_top.sv
verification/rename_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rename_tb -f list.f -o rename_sim

result=$(./obj_dir/rename_sim || true)
echo "$result"
echo "$result" | grep -qF "All tests passed"
